//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       := tb_blob_extractor
FILELIST  := build.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := FAIL: see errors above
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
design/blob_geom_pkg.sv
design/blob_record_pkg.sv
design/seed_stack.sv
design/fill_walker.sv
design/blob_record_writer.sv
design/blob_extractor.sv
sim/blob_extractor_sva.sv
sim/blob_checker.sv
sim/tb_blob_extractor.sv

//--- design/blob_extractor.sv
`default_nettype none

module blob_extractor (
	input  wire                           clk,
	input  wire                           arst_n,
	input  wire                           enable,
	input  wire blob_geom_pkg::pixel_t    data_read,
	output blob_geom_pkg::addr_t          address,
	output logic                          wren,
	output blob_geom_pkg::pixel_t         data_write,
	output logic                          record_valid,
	output blob_record_pkg::rec_addr_t    record_addr,
	output blob_record_pkg::record_word_t record_word,
	output blob_geom_pkg::label_t         blob_count,
	output logic                          done,
	output logic                          stack_overflow
);

	// Walker to stack
	logic                  push;
	logic                  pop;
	logic                  clear;
	logic                  empty;
	blob_geom_pkg::seed_t  push_seed;
	blob_geom_pkg::seed_t  pop_seed;

	// Walker to record writer
	logic                  frame_start;
	logic                  blob_start;
	logic                  pixel_strobe;
	logic                  blob_end;
	logic                  scan_end;
	blob_geom_pkg::label_t blob_label;
	blob_geom_pkg::coord_t pixel_x;
	blob_geom_pkg::coord_t pixel_y;

	fill_walker u_walker (
		.clk          (clk),
		.arst_n       (arst_n),
		.enable       (enable),
		.data_read    (data_read),
		.pop_seed     (pop_seed),
		.empty        (empty),
		.address      (address),
		.wren         (wren),
		.data_write   (data_write),
		.push         (push),
		.push_seed    (push_seed),
		.pop          (pop),
		.clear        (clear),
		.frame_start  (frame_start),
		.blob_start   (blob_start),
		.blob_label   (blob_label),
		.pixel_strobe (pixel_strobe),
		.pixel_x      (pixel_x),
		.pixel_y      (pixel_y),
		.blob_end     (blob_end),
		.scan_end     (scan_end)
	);

	seed_stack u_stack (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (push),
		.push_seed (push_seed),
		.pop       (pop),
		.clear     (clear),
		.pop_seed  (pop_seed),
		.empty     (empty),
		.overflow  (stack_overflow)
	);

	blob_record_writer u_writer (
		.clk          (clk),
		.arst_n       (arst_n),
		.frame_start  (frame_start),
		.blob_start   (blob_start),
		.blob_label   (blob_label),
		.pixel_strobe (pixel_strobe),
		.pixel_x      (pixel_x),
		.pixel_y      (pixel_y),
		.blob_end     (blob_end),
		.scan_end     (scan_end),
		.record_valid (record_valid),
		.record_addr  (record_addr),
		.record_word  (record_word),
		.blob_count   (blob_count),
		.done         (done)
	);

endmodule

`default_nettype wire

//--- design/blob_geom_pkg.sv
`default_nettype none

package blob_geom_pkg;

	// Image size in pixels
	localparam int IMG_W  = 16;
	localparam int IMG_H  = 12;
	// Border that the scan and the fill never touch
	localparam int MARGIN = 1;

	localparam int STACK_DEPTH = 256;
	localparam int STACK_AW    = $clog2(STACK_DEPTH);

	typedef logic [7:0]  coord_t;
	typedef logic [7:0]  addr_t;
	typedef logic [15:0] pixel_t;
	typedef logic [15:0] label_t;
	// x in the upper byte, y in the lower byte
	typedef logic [15:0] seed_t;

	// Inclusive bounds of the inner window
	localparam coord_t X_MIN = coord_t'(MARGIN);
	localparam coord_t X_MAX = coord_t'(IMG_W - 1 - MARGIN);
	localparam coord_t Y_MIN = coord_t'(MARGIN);
	localparam coord_t Y_MAX = coord_t'(IMG_H - 1 - MARGIN);

	// 0 is unlabelled foreground, 1 is background, labels start above
	localparam pixel_t PIX_FG      = pixel_t'(0);
	localparam label_t FIRST_LABEL = label_t'(2);

endpackage

`default_nettype wire

//--- design/blob_record_pkg.sv
`default_nettype none

package blob_record_pkg;

	typedef logic [31:0] record_word_t;
	typedef logic [7:0]  rec_addr_t;

	localparam int           WORDS_PER_RECORD = 2;
	localparam record_word_t TERM_WORD        = '1;

	// Word 0 is label over size
	function automatic record_word_t make_word0(logic [15:0] label, logic [15:0] size);
		return {label, size};
	endfunction

	// Word 1 is the bounding box with min x in the top byte
	function automatic record_word_t make_word1(logic [7:0] min_x, logic [7:0] min_y,
			logic [7:0] max_x, logic [7:0] max_y);
		return {min_x, min_y, max_x, max_y};
	endfunction

endpackage

`default_nettype wire

//--- design/blob_record_writer.sv
`default_nettype none

module blob_record_writer (
	input  wire                           clk,
	input  wire                           arst_n,
	input  wire                           frame_start,
	input  wire                           blob_start,
	input  wire blob_geom_pkg::label_t    blob_label,
	input  wire                           pixel_strobe,
	input  wire blob_geom_pkg::coord_t    pixel_x,
	input  wire blob_geom_pkg::coord_t    pixel_y,
	input  wire                           blob_end,
	input  wire                           scan_end,
	output logic                          record_valid,
	output blob_record_pkg::rec_addr_t    record_addr,
	output blob_record_pkg::record_word_t record_word,
	output blob_geom_pkg::label_t         blob_count,
	output logic                          done
);

	typedef enum logic [2:0] {
		S_IDLE, S_WORD0, S_WORD1, S_TERM0, S_TERM1
	} state_t;

	state_t                        state;
	blob_geom_pkg::label_t         cur_label;
	logic [15:0]                   blob_size;
	blob_geom_pkg::coord_t         min_x;
	blob_geom_pkg::coord_t         min_y;
	blob_geom_pkg::coord_t         max_x;
	blob_geom_pkg::coord_t         max_y;
	blob_record_pkg::record_word_t word0_q;
	blob_record_pkg::record_word_t word1_q;
	blob_record_pkg::rec_addr_t    rec_base;

	always_comb begin
		record_valid = (state != S_IDLE);
		record_addr  = rec_base;
		record_word  = blob_record_pkg::TERM_WORD;
		case (state)
			S_WORD0: record_word = word0_q;
			S_WORD1: begin
				record_addr = rec_base + blob_record_pkg::rec_addr_t'(1);
				record_word = word1_q;
			end
			S_TERM1: record_addr = rec_base + blob_record_pkg::rec_addr_t'(1);
			default: record_word = blob_record_pkg::TERM_WORD;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= S_IDLE;
			blob_count <= '0;
			done       <= 1'b0;
		end else begin
			if (frame_start) begin
				blob_count <= '0;
				done       <= 1'b0;
			end
			case (state)
				S_IDLE: begin
					if (blob_end) begin
						blob_count <= blob_count + 1'b1;
						state      <= S_WORD0;
					end else if (scan_end) begin
						state <= S_TERM0;
					end
				end
				S_WORD0: state <= S_WORD1;
				S_WORD1: state <= S_IDLE;
				S_TERM0: state <= S_TERM1;
				S_TERM1: begin
					state <= S_IDLE;
					done  <= 1'b1;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Running size and bounding box of the blob being filled
	always_ff @(posedge clk) begin
		if (blob_start) begin
			cur_label <= blob_label;
			blob_size <= '0;
			min_x     <= '1;
			min_y     <= '1;
			max_x     <= '0;
			max_y     <= '0;
		end else if (pixel_strobe) begin
			blob_size <= blob_size + 1'b1;
			if (pixel_x < min_x) begin
				min_x <= pixel_x;
			end
			if (pixel_x > max_x) begin
				max_x <= pixel_x;
			end
			if (pixel_y < min_y) begin
				min_y <= pixel_y;
			end
			if (pixel_y > max_y) begin
				max_y <= pixel_y;
			end
		end
		// Record words are latched as the blob ends
		if (blob_end) begin
			word0_q <= blob_record_pkg::make_word0(cur_label, blob_size);
			word1_q <= blob_record_pkg::make_word1(min_x, min_y, max_x, max_y);
		end
		if (blob_end || scan_end) begin
			rec_base <= blob_record_pkg::rec_addr_t'(blob_count *
				blob_record_pkg::WORDS_PER_RECORD);
		end
	end

endmodule

`default_nettype wire

//--- design/fill_walker.sv
`default_nettype none

module fill_walker (
	input  wire                          clk,
	input  wire                          arst_n,
	input  wire                          enable,
	input  wire blob_geom_pkg::pixel_t   data_read,
	input  wire blob_geom_pkg::seed_t    pop_seed,
	input  wire                          empty,
	output blob_geom_pkg::addr_t         address,
	output logic                         wren,
	output blob_geom_pkg::pixel_t        data_write,
	output logic                         push,
	output blob_geom_pkg::seed_t         push_seed,
	output logic                         pop,
	output logic                         clear,
	output logic                         frame_start,
	output logic                         blob_start,
	output blob_geom_pkg::label_t        blob_label,
	output logic                         pixel_strobe,
	output blob_geom_pkg::coord_t        pixel_x,
	output blob_geom_pkg::coord_t        pixel_y,
	output logic                         blob_end,
	output logic                         scan_end
);

	typedef enum logic [2:0] {
		S_IDLE, S_SCAN_ADDR, S_SCAN_TEST, S_POP,
		S_FETCH, S_TEST, S_PUSH_NB, S_FINISH
	} state_t;

	state_t                state;
	logic                  enable_q;
	logic                  start_edge;
	logic                  scan_done;
	logic                  is_fg;
	blob_geom_pkg::coord_t scan_x;
	blob_geom_pkg::coord_t scan_y;
	blob_geom_pkg::coord_t cur_x;
	blob_geom_pkg::coord_t cur_y;
	blob_geom_pkg::coord_t nb_x;
	blob_geom_pkg::coord_t nb_y;
	blob_geom_pkg::label_t label;
	logic [1:0]            nb_idx;

	function automatic blob_geom_pkg::addr_t pix_addr(blob_geom_pkg::coord_t x,
			blob_geom_pkg::coord_t y);
		return blob_geom_pkg::addr_t'(int'(y) * blob_geom_pkg::IMG_W + int'(x));
	endfunction

	function automatic logic in_window(blob_geom_pkg::coord_t x, blob_geom_pkg::coord_t y);
		return (x >= blob_geom_pkg::X_MIN) && (x <= blob_geom_pkg::X_MAX) &&
			(y >= blob_geom_pkg::Y_MIN) && (y <= blob_geom_pkg::Y_MAX);
	endfunction

	assign start_edge = enable && !enable_q;
	assign scan_done  = (scan_y > blob_geom_pkg::Y_MAX);
	assign is_fg      = (data_read == blob_geom_pkg::PIX_FG);

	assign data_write = label;
	assign blob_label = label;
	assign pixel_x    = cur_x;
	assign pixel_y    = cur_y;

	// Neighbour order is left, right, up, down
	always_comb begin
		nb_x = cur_x;
		nb_y = cur_y;
		case (nb_idx)
			2'd0: nb_x = cur_x - 1'b1;
			2'd1: nb_x = cur_x + 1'b1;
			2'd2: nb_y = cur_y - 1'b1;
			default: nb_y = cur_y + 1'b1;
		endcase
	end

	always_comb begin
		address      = pix_addr(scan_x, scan_y);
		wren         = 1'b0;
		push         = 1'b0;
		push_seed    = {scan_x, scan_y};
		pop          = 1'b0;
		clear        = 1'b0;
		frame_start  = 1'b0;
		blob_start   = 1'b0;
		pixel_strobe = 1'b0;
		blob_end     = 1'b0;
		scan_end     = 1'b0;
		case (state)
			S_IDLE: begin
				clear       = start_edge;
				frame_start = start_edge;
			end
			S_SCAN_ADDR: scan_end = scan_done;
			S_SCAN_TEST: begin
				// An unlabelled pixel becomes the first seed
				blob_start = is_fg;
				push       = is_fg;
			end
			S_POP: pop = !empty;
			// Stack output is registered, so its address goes straight out
			S_FETCH: address = pix_addr(pop_seed[15:8], pop_seed[7:0]);
			S_TEST: begin
				address      = pix_addr(cur_x, cur_y);
				wren         = is_fg;
				pixel_strobe = is_fg;
			end
			S_PUSH_NB: begin
				push      = in_window(nb_x, nb_y);
				push_seed = {nb_x, nb_y};
			end
			S_FINISH: blob_end = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= S_IDLE;
			enable_q <= 1'b0;
			scan_x   <= '0;
			scan_y   <= '0;
			label    <= '0;
			nb_idx   <= '0;
		end else begin
			enable_q <= enable;
			case (state)
				S_IDLE: begin
					if (start_edge) begin
						scan_x <= blob_geom_pkg::X_MIN;
						scan_y <= blob_geom_pkg::Y_MIN;
						label  <= blob_geom_pkg::FIRST_LABEL;
						state  <= S_SCAN_ADDR;
					end
				end
				S_SCAN_ADDR: state <= scan_done ? S_IDLE : S_SCAN_TEST;
				S_SCAN_TEST: begin
					if (is_fg) begin
						state <= S_POP;
					end else begin
						if (scan_x == blob_geom_pkg::X_MAX) begin
							scan_x <= blob_geom_pkg::X_MIN;
							scan_y <= scan_y + 1'b1;
						end else begin
							scan_x <= scan_x + 1'b1;
						end
						state <= S_SCAN_ADDR;
					end
				end
				S_POP: state <= empty ? S_FINISH : S_FETCH;
				S_FETCH: state <= S_TEST;
				// Pixel already labelled through another path is skipped
				S_TEST: state <= is_fg ? S_PUSH_NB : S_POP;
				S_PUSH_NB: begin
					nb_idx <= nb_idx + 1'b1;
					if (nb_idx == 2'd3) begin
						state <= S_POP;
					end
				end
				S_FINISH: begin
					// Scan resumes on the seed pixel, which now reads back as labelled
					label <= label + 1'b1;
					state <= S_SCAN_ADDR;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_FETCH) begin
			cur_x <= pop_seed[15:8];
			cur_y <= pop_seed[7:0];
		end
	end

endmodule

`default_nettype wire

//--- design/seed_stack.sv
`default_nettype none

module seed_stack (
	input  wire                          clk,
	input  wire                          arst_n,
	input  wire                          push,
	input  wire blob_geom_pkg::seed_t    push_seed,
	input  wire                          pop,
	input  wire                          clear,
	output blob_geom_pkg::seed_t         pop_seed,
	output logic                         empty,
	output logic                         overflow
);

	// Entry count is one bit wider than the index so full and empty differ
	logic [blob_geom_pkg::STACK_AW:0]   count;
	logic [blob_geom_pkg::STACK_AW-1:0] top_idx;
	logic                               full;
	blob_geom_pkg::seed_t               mem [blob_geom_pkg::STACK_DEPTH];

	assign full    = (count == (blob_geom_pkg::STACK_AW + 1)'(blob_geom_pkg::STACK_DEPTH));
	assign empty   = (count == '0);
	assign top_idx = count[blob_geom_pkg::STACK_AW-1:0] - 1'b1;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count    <= '0;
			overflow <= 1'b0;
		end else if (clear) begin
			count    <= '0;
			overflow <= 1'b0;
		end else if (push) begin
			// A push onto a full stack is dropped and flagged
			if (full) begin
				overflow <= 1'b1;
			end else begin
				count <= count + 1'b1;
			end
		end else if (pop && !empty) begin
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push && !full && !clear) begin
			mem[count[blob_geom_pkg::STACK_AW-1:0]] <= push_seed;
		end
		if (pop && !empty) begin
			pop_seed <= mem[top_idx];
		end
	end

endmodule

`default_nettype wire

//--- sim/blob_checker.sv
`default_nettype none

module blob_checker (
	input  wire              clk,
	input  wire              arst_n,
	input  wire              record_valid,
	input  wire  [7:0]       record_addr,
	input  wire  [31:0]      record_word,
	input  wire  [15:0]      blob_count,
	input  wire              done,
	input  var logic [15:0]  img [blob_geom_pkg::IMG_H],
	input  var int           exp_count,
	input  var int           exp_rec [3][6],
	input  var logic [15:0]  mem [blob_geom_pkg::IMG_H * blob_geom_pkg::IMG_W],
	output int               errors,
	output int               tests_checked
);

	timeunit 1ns;
	timeprecision 1ns;

	localparam int W = blob_geom_pkg::IMG_W;
	localparam int H = blob_geom_pkg::IMG_H;
	localparam int M = blob_geom_pkg::MARGIN;

	int   rec_seen;
	logic done_q;

	// Word n of the record sequence with terminators after the last blob
	function automatic logic [31:0] expected_word(int idx);
		int rec;
		rec = idx / 2;
		if (idx >= 2 * exp_count) begin
			return '1;
		end
		if (idx % 2 == 0) begin
			return {exp_rec[rec][0][15:0], exp_rec[rec][1][15:0]};
		end
		return {exp_rec[rec][2][7:0], exp_rec[rec][3][7:0],
			exp_rec[rec][4][7:0], exp_rec[rec][5][7:0]};
	endfunction

	task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
		$display("FAILED at %0t ns: %s expected %h got %h", $time, name, expected, actual);
		errors++;
	endtask

	task automatic report_problem(string text);
		$display("ERROR at %0t ns: %s", $time, text);
		errors++;
	endtask

	task automatic check_memory;
		int   tally [3];
		int   a;
		int   idx;
		logic fg;
		logic in_win;
		tally = '{0, 0, 0};
		for (int y = 0; y < H; y++) begin
			for (int x = 0; x < W; x++) begin
				a      = y * W + x;
				fg     = img[y][W - 1 - x];
				in_win = (x >= M) && (x < W - M) && (y >= M) && (y < H - M);
				if (!(fg && in_win)) begin
					// Background and margin pixels keep their loaded value
					if (mem[a] !== (fg ? 16'h0000 : 16'h0001)) begin
						report_mismatch($sformatf("mem[%0d]", a), fg ? 32'h0 : 32'h1, 32'(mem[a]));
					end
				end else begin
					idx = -1;
					for (int i = 0; i < exp_count; i++) begin
						if (32'(mem[a]) == exp_rec[i][0]) begin
							idx = i;
						end
					end
					if (idx < 0) begin
						report_problem($sformatf("pixel (%0d,%0d) holds %h, which is no blob label",
							x, y, mem[a]));
					end else begin
						tally[idx]++;
						if (x < exp_rec[idx][2] || x > exp_rec[idx][4] ||
							y < exp_rec[idx][3] || y > exp_rec[idx][5]) begin
							report_problem($sformatf("pixel (%0d,%0d) lies outside the box of label %0d",
								x, y, exp_rec[idx][0]));
						end
					end
				end
			end
		end
		for (int i = 0; i < exp_count; i++) begin
			if (tally[i] != exp_rec[i][1]) begin
				report_mismatch($sformatf("pixels with label %0d", exp_rec[i][0]),
					exp_rec[i][1], tally[i]);
			end
		end
	endtask

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rec_seen      = 0;
			done_q        = 1'b0;
			errors        = 0;
			tests_checked = 0;
		end else begin
			if (record_valid) begin
				if (rec_seen > 2 * exp_count + 1) begin
					report_problem("record word written after the terminator");
				end else begin
					if (record_addr !== 8'(rec_seen)) begin
						report_mismatch("record_addr", rec_seen, 32'(record_addr));
					end
					if (record_word !== expected_word(rec_seen)) begin
						report_mismatch("record_word", expected_word(rec_seen), record_word);
					end
				end
				rec_seen++;
			end
			if (done && !done_q) begin
				if (rec_seen != 2 * exp_count + 2) begin
					report_mismatch("record word count", 2 * exp_count + 2, rec_seen);
				end
				if (blob_count !== 16'(exp_count)) begin
					report_mismatch("blob_count", exp_count, 32'(blob_count));
				end
				check_memory();
				rec_seen = 0;
				tests_checked++;
			end
			done_q = done;
		end
	end

endmodule

`default_nettype wire

//--- sim/blob_extractor_sva.sv
`default_nettype none

module blob_extractor_sva (
	input wire       clk,
	input wire       arst_n,
	input wire       wren,
	input wire       done,
	input wire       record_valid,
	input wire       stack_overflow,
	input wire [7:0] address
);

	timeunit 1ns;
	timeprecision 1ns;

	localparam int W = blob_geom_pkg::IMG_W;
	localparam int H = blob_geom_pkg::IMG_H;
	localparam int M = blob_geom_pkg::MARGIN;

	a_no_write_when_done: assert property (@(posedge clk) disable iff (!arst_n)
		!(wren && done)) else $error("wren high while done is high");

	// Writes stay inside the inner window
	a_write_in_window: assert property (@(posedge clk) disable iff (!arst_n)
		wren |-> ((int'(address) % W) >= M) && ((int'(address) % W) < W - M) &&
			((int'(address) / W) >= M) && ((int'(address) / W) < H - M))
		else $error("write to address %0d outside the window", address);

	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		!stack_overflow) else $error("seed stack overflowed");

	a_no_record_when_done: assert property (@(posedge clk) disable iff (!arst_n)
		!(record_valid && done)) else $error("record_valid high while done is high");

endmodule

bind blob_extractor blob_extractor_sva u_sva (
	.clk            (clk),
	.arst_n         (arst_n),
	.wren           (wren),
	.done           (done),
	.record_valid   (record_valid),
	.stack_overflow (stack_overflow),
	.address        (address)
);

`default_nettype wire

//--- sim/tb_blob_extractor.sv
`default_nettype none

module tb_blob_extractor;

	timeunit 1ns;
	timeprecision 1ns;

	localparam int NUM_TESTS  = 6;
	localparam int NUM_ROWS   = blob_geom_pkg::IMG_H;
	localparam int ROW_W      = blob_geom_pkg::IMG_W;
	localparam int NUM_PIX    = NUM_ROWS * ROW_W;
	localparam int DONE_LIMIT = 5000;

	logic        clk;
	logic        arst_n;
	logic        enable;
	logic [15:0] data_read = 16'h0001;
	logic [7:0]  address;
	logic        wren;
	logic [15:0] data_write;
	logic        record_valid;
	logic [7:0]  record_addr;
	logic [31:0] record_word;
	logic [15:0] blob_count;
	logic        done;
	logic        stack_overflow;

	logic        load;
	logic        timed_out;
	logic [15:0] mem [NUM_PIX];
	// A set bit is a foreground pixel and the MSB of a row is x 0
	logic [15:0] img_tab [NUM_TESTS][NUM_ROWS];
	logic [15:0] cur_img [NUM_ROWS];
	// Each record is label, size, min x, min y, max x, max y
	int          exp_tab [NUM_TESTS][3][6];
	int          exp_count [NUM_TESTS];
	int          cur_rec [3][6];
	int          cur_count;
	string       test_name [NUM_TESTS];
	int          errors;
	int          tests_checked;

	blob_extractor u_dut (
		.clk            (clk),
		.arst_n         (arst_n),
		.enable         (enable),
		.data_read      (data_read),
		.address        (address),
		.wren           (wren),
		.data_write     (data_write),
		.record_valid   (record_valid),
		.record_addr    (record_addr),
		.record_word    (record_word),
		.blob_count     (blob_count),
		.done           (done),
		.stack_overflow (stack_overflow)
	);

	blob_checker u_checker (
		.clk           (clk),
		.arst_n        (arst_n),
		.record_valid  (record_valid),
		.record_addr   (record_addr),
		.record_word   (record_word),
		.blob_count    (blob_count),
		.done          (done),
		.img           (cur_img),
		.exp_count     (cur_count),
		.exp_rec       (cur_rec),
		.mem           (mem),
		.errors        (errors),
		.tests_checked (tests_checked)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Image memory with one cycle read latency
	always @(posedge clk) begin
		if (load) begin
			for (int i = 0; i < NUM_PIX; i++) begin
				mem[i] <= cur_img[i / ROW_W][ROW_W - 1 - (i % ROW_W)] ? 16'h0000 : 16'h0001;
			end
		end else if (wren) begin
			mem[address] <= data_write;
		end
		data_read <= mem[address];
	end

	task automatic build_table;
		test_name[0] = "empty image";
		img_tab[0]   = '{default: 16'h0000};
		exp_count[0] = 0;

		test_name[1] = "single rectangle";
		img_tab[1]   = '{16'h0000, 16'h0000, 16'h1E00, 16'h1E00, 16'h1E00, 16'h0000,
			16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000};
		exp_count[1] = 1;
		exp_tab[1][0] = '{2, 12, 3, 2, 6, 4};

		test_name[2] = "two blobs";
		img_tab[2]   = '{16'h0000, 16'h0000, 16'h3000, 16'h3000, 16'h0000, 16'h00E0,
			16'h00E0, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000};
		exp_count[2] = 2;
		exp_tab[2][0] = '{2, 4, 2, 2, 3, 3};
		exp_tab[2][1] = '{3, 6, 8, 5, 10, 6};

		// U opens upward and the diagonal pair touches only at a corner
		test_name[3] = "U shape and diagonal";
		img_tab[3]   = '{16'h0000, 16'h0000, 16'h00A0, 16'h00A0, 16'h00E0, 16'h0000,
			16'h1000, 16'h0800, 16'h0000, 16'h0000, 16'h0000, 16'h0000};
		exp_count[3] = 3;
		exp_tab[3][0] = '{2, 7, 8, 2, 10, 4};
		exp_tab[3][1] = '{3, 1, 3, 6, 3, 6};
		exp_tab[3][2] = '{4, 1, 4, 7, 4, 7};

		test_name[4] = "margin pixels";
		img_tab[4]   = '{16'hFFFF, 16'h4001, 16'h0001, 16'h0001, 16'h0001, 16'h0001,
			16'h0001, 16'h0001, 16'h0001, 16'h0007, 16'h0007, 16'hFFFF};
		exp_count[4] = 2;
		exp_tab[4][0] = '{2, 1, 1, 1, 1, 1};
		exp_tab[4][1] = '{3, 4, 13, 9, 14, 10};

		test_name[5] = "corner pixel and long row";
		img_tab[5]   = '{16'h0000, 16'h0002, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
			16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h7FFE, 16'h0000};
		exp_count[5] = 2;
		exp_tab[5][0] = '{2, 1, 14, 1, 14, 1};
		exp_tab[5][1] = '{3, 14, 1, 10, 14, 10};
	endtask

	task automatic wait_for_done(input logic level, input int limit);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (done !== level && cycles < limit);
		if (done !== level) begin
			$display("Timed out after %0d cycles waiting for done to be %0b", limit, level);
			timed_out = 1'b1;
		end
	endtask

	initial begin
		int cycles;
		int errors_before;
		int tests_run;
		int failed_tests;
		arst_n       = 1'b0;
		enable       = 1'b0;
		load         = 1'b0;
		timed_out    = 1'b0;
		cur_count    = 0;
		tests_run    = 0;
		failed_tests = 0;
		build_table();
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
			errors_before = errors;
			cur_img       = img_tab[t];
			cur_count     = exp_count[t];
			cur_rec       = exp_tab[t];
			load <= 1'b1;
			@(posedge clk);
			load <= 1'b0;
			@(posedge clk);
			enable <= 1'b1;
			// done from the previous frame drops once the new frame starts
			wait_for_done(1'b0, 10);
			if (!timed_out) begin
				wait_for_done(1'b1, DONE_LIMIT);
			end
			cycles = 0;
			while (!timed_out && tests_checked != t + 1 && cycles < 10) begin
				@(negedge clk);
				cycles++;
			end
			if (!timed_out && tests_checked != t + 1) begin
				$display("Checker never finished its checks for test %0d", t);
				timed_out = 1'b1;
			end
			@(posedge clk);
			enable <= 1'b0;
			@(posedge clk);
			tests_run++;
			if (timed_out) begin
				failed_tests++;
				$display("Test %0d %s: timed out", t, test_name[t]);
			end else if (errors != errors_before) begin
				failed_tests++;
				$display("Test %0d %s: %0d errors", t, test_name[t], errors - errors_before);
			end else begin
				$display("Test %0d %s: ok", t, test_name[t]);
			end
		end
		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, failed_tests, errors);
		if (errors == 0 && failed_tests == 0 && !timed_out) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire
